// File: include/emu_cfg.svh
`ifndef EMU_CFG_SVH
`define EMU_CFG_SVH

// symbol and chunk geometry
`define EMU_BITS_PER_SYMBOL 2
`define EMU_CHUNK_SYMS      2  // symbols per table lookup
`define EMU_NUM_CHUNKS      4
`define EMU_NUM_SLICES      4  // also new symbols per frame word
`define EMU_HIST_SYMS       12 // three frame words

// datapath widths
`define EMU_COEF_WIDTH      12
`define EMU_SUM_WIDTH       14
`define EMU_MAG_WIDTH       10

// step response table
`define EMU_TBL_DEPTH       64

// flow control
`define EMU_IN_CREDITS      2  // input buffer depth
`define EMU_OUT_CREDITS     2

`endif

// File: hw/emu_pkg.sv
`include "emu_cfg.svh"

package emu_pkg;

    localparam int TBL_AW = $clog2(`EMU_TBL_DEPTH);
    localparam int SYM_W  = `EMU_BITS_PER_SYMBOL;

    // symbol 0 is the oldest and sits in the low bits
    typedef struct packed {
        logic [`EMU_NUM_SLICES-1:0][SYM_W-1:0] sym;
    } sym_word_t;

    typedef struct packed {
        logic                      sign; // set for a negative sum
        logic [`EMU_MAG_WIDTH-1:0] mag;
    } slice_smp_t;

    // slice 0 in the low bits
    typedef struct packed {
        slice_smp_t [`EMU_NUM_SLICES-1:0] slc;
    } sample_t;

    typedef struct packed {
        logic                       en;
        logic [TBL_AW-1:0]          addr;
        logic [`EMU_COEF_WIDTH-1:0] data;
    } tbl_wr_t;

    // addr is {chunk index, chunk value}
    typedef struct packed {
        logic              valid;
        logic [TBL_AW-1:0] addr;
    } tbl_rd_req_t;

endpackage

// File: hw/frame_sequencer.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module frame_sequencer (
    input  logic                                           emu_clk,
    input  logic                                           emu_rst,
    input  logic                                           sym_valid_i,
    input  emu_pkg::sym_word_t                             sym_word_i,
    input  logic [`EMU_NUM_SLICES-1:0]                     slice_done_i,
    input  emu_pkg::sample_t                               slice_smp_i,
    input  logic                                           smp_credit_i,
    output logic                                           sym_credit_o,
    output logic [`EMU_HIST_SYMS*`EMU_BITS_PER_SYMBOL-1:0] history_o,
    output logic                                           start_o,
    output logic                                           smp_valid_o,
    output emu_pkg::sample_t                               smp_o
);
    import emu_pkg::*;

    localparam int HIST_W = `EMU_HIST_SYMS * `EMU_BITS_PER_SYMBOL;
    localparam int WORD_W = $bits(sym_word_t);
    localparam int PTR_W  = $clog2(`EMU_IN_CREDITS);
    localparam int CNT_W  = $clog2(`EMU_IN_CREDITS + 1);
    localparam int CRED_W = $clog2(`EMU_OUT_CREDITS + 1);

    sym_word_t         buf_mem [`EMU_IN_CREDITS];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  buf_cnt_q;
    logic [HIST_W-1:0] hist_q;   // position 0 oldest, in the low bits
    logic [CRED_W-1:0] out_cred_q;
    logic              busy_q;   // frame in flight
    logic              smp_valid_q;
    sample_t           smp_q;
    logic              frame_done;

    // a credit being spent by this cycle's record cannot back a new frame
    assign start_o = (buf_cnt_q != '0) && (out_cred_q > CRED_W'(smp_valid_q)) && !busy_q;
    assign sym_credit_o = start_o; // one return per popped word

    assign frame_done = busy_q && (&slice_done_i);

    // slices latch their windows at start, so show the shifted history then
    assign history_o = start_o ? {buf_mem[rd_ptr_q], hist_q[HIST_W-1:WORD_W]} : hist_q;

    always_ff @(posedge emu_clk) begin
        if (sym_valid_i) begin
            buf_mem[wr_ptr_q] <= sym_word_i;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            buf_cnt_q   <= '0;
            hist_q      <= '0;
            out_cred_q  <= CRED_W'(`EMU_OUT_CREDITS);
            busy_q      <= 1'b0;
            smp_valid_q <= 1'b0;
        end else begin
            if (sym_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (start_o) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                hist_q   <= history_o;
            end
            buf_cnt_q  <= buf_cnt_q + CNT_W'(sym_valid_i) - CNT_W'(start_o);
            out_cred_q <= out_cred_q + CRED_W'(smp_credit_i) - CRED_W'(smp_valid_q);

            if (start_o) begin
                busy_q <= 1'b1;
            end else if (frame_done) begin
                busy_q <= 1'b0;
            end
            smp_valid_q <= frame_done; // record leaves the cycle after all slices finish
        end
    end

    always_ff @(posedge emu_clk) begin
        if (frame_done) begin
            smp_q <= slice_smp_i;
        end
    end

    assign smp_valid_o = smp_valid_q;
    assign smp_o       = smp_q;

endmodule

// File: hw/response_slice.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module response_slice #(
    parameter int SLICE_IDX = 0
) (
    input  logic                                           emu_clk,
    input  logic                                           emu_rst,
    input  logic                                           start_i,
    input  logic [`EMU_HIST_SYMS*`EMU_BITS_PER_SYMBOL-1:0] history_i,
    input  logic                                           rd_ack_i,
    input  logic [`EMU_COEF_WIDTH-1:0]                     rd_data_i,
    output emu_pkg::tbl_rd_req_t                           rd_req_o,
    output logic                                           done_o,
    output emu_pkg::slice_smp_t                            smp_o
);
    import emu_pkg::*;

    localparam int CHUNK_W = `EMU_CHUNK_SYMS * `EMU_BITS_PER_SYMBOL;
    localparam int WIN_W   = `EMU_NUM_CHUNKS * CHUNK_W;
    localparam int WIN_LO  = (SLICE_IDX + 1) * `EMU_BITS_PER_SYMBOL; // position j+1
    localparam int IDX_W   = $clog2(`EMU_NUM_CHUNKS);
    localparam int SUM_W   = `EMU_SUM_WIDTH;
    localparam int COEF_W  = `EMU_COEF_WIDTH;
    localparam int MAG_MAX = (1 << `EMU_MAG_WIDTH) - 1;

    logic [WIN_W-1:0]        window_q;
    logic [IDX_W-1:0]        chunk_q;  // chunk being fetched
    logic                    active_q;
    logic                    done_q;
    logic signed [SUM_W-1:0] acc_q;
    logic signed [SUM_W-1:0] acc_next;
    logic [SUM_W-1:0]        abs_sum;
    slice_smp_t              smp_q;
    slice_smp_t              smp_next;
    logic                    last_chunk;

    // dropped in the ack cycle so a served request is not granted again
    assign rd_req_o.valid = active_q && !rd_ack_i;
    assign rd_req_o.addr  = {chunk_q, window_q[chunk_q*CHUNK_W +: CHUNK_W]};

    assign last_chunk = (chunk_q == IDX_W'(`EMU_NUM_CHUNKS - 1));

    assign acc_next = acc_q + {{(SUM_W-COEF_W){rd_data_i[COEF_W-1]}}, rd_data_i};
    assign abs_sum  = acc_next[SUM_W-1] ? -acc_next : acc_next;

    always_comb begin
        smp_next.sign = acc_next[SUM_W-1];
        smp_next.mag  = (abs_sum > MAG_MAX) ? '1 : abs_sum[`EMU_MAG_WIDTH-1:0]; // clip
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            chunk_q  <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            done_q   <= 1'b0;
            chunk_q  <= '0;
        end else if (rd_ack_i && active_q) begin
            if (last_chunk) begin
                active_q <= 1'b0;
                done_q   <= 1'b1;
            end else begin
                chunk_q <= chunk_q + 1'b1;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (start_i) begin
            window_q <= history_i[WIN_LO +: WIN_W];
            acc_q    <= '0;
        end else if (rd_ack_i && active_q) begin
            acc_q <= acc_next;
            if (last_chunk) begin
                smp_q <= smp_next; // held until the next start
            end
        end
    end

    assign done_o = done_q;
    assign smp_o  = smp_q;

endmodule

// File: hw/table_arbiter.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module table_arbiter (
    input  logic                       emu_clk,
    input  logic                       emu_rst,
    input  emu_pkg::tbl_rd_req_t       req_i [`EMU_NUM_SLICES],
    input  logic                       tbl_busy_i,
    input  logic [`EMU_COEF_WIDTH-1:0] rd_data_i,
    output logic [`EMU_NUM_SLICES-1:0] grant_o,
    output emu_pkg::tbl_rd_req_t       tbl_req_o,
    output logic [`EMU_NUM_SLICES-1:0] ack_o,
    output logic [`EMU_COEF_WIDTH-1:0] rd_data_o
);
    localparam int N     = `EMU_NUM_SLICES;
    localparam int SEL_W = $clog2(N);

    logic [SEL_W-1:0] last_q; // slice served last
    logic [SEL_W-1:0] sel;
    logic [N-1:0]     grant;
    logic [N-1:0]     ack_q;

    // search starts one past the last winner; writes hold off all reads
    always_comb begin
        logic [SEL_W-1:0] idx;
        grant = '0;
        sel   = last_q;
        for (int i = 1; i <= N; i++) begin
            idx = SEL_W'(last_q + i);
            if ((grant == '0) && req_i[idx].valid && !tbl_busy_i) begin
                grant[idx] = 1'b1;
                sel        = idx;
            end
        end
    end

    assign tbl_req_o.valid = |grant;
    assign tbl_req_o.addr  = req_i[sel].addr;
    assign grant_o         = grant;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            last_q <= SEL_W'(N - 1); // slice 0 goes first
            ack_q  <= '0;
        end else begin
            ack_q <= grant; // table data lands one cycle after the grant
            if (|grant) begin
                last_q <= sel;
            end
        end
    end

    assign ack_o     = ack_q;
    assign rd_data_o = rd_data_i; // shared return bus, ack picks the receiver

endmodule

// File: hw/response_table.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module response_table (
    input  logic                       emu_clk,
    input  emu_pkg::tbl_wr_t           tbl_wr_i,
    input  emu_pkg::tbl_rd_req_t       rd_req_i,
    output logic                       tbl_busy_o,
    output logic [`EMU_COEF_WIDTH-1:0] rd_data_o
);
    logic [`EMU_COEF_WIDTH-1:0] mem [`EMU_TBL_DEPTH];
    logic [`EMU_COEF_WIDTH-1:0] rd_data_q;

    // single port, a write owns it for the cycle
    assign tbl_busy_o = tbl_wr_i.en;

    always_ff @(posedge emu_clk) begin
        if (tbl_wr_i.en) begin
            mem[tbl_wr_i.addr] <= tbl_wr_i.data;
        end else if (rd_req_i.valid) begin
            rd_data_q <= mem[rd_req_i.addr];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

// File: hw/adc_emu_top.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module adc_emu_top (
    input  logic               emu_clk,
    input  logic               emu_rst,
    input  logic               sym_valid_i,
    input  emu_pkg::sym_word_t sym_word_i,
    input  logic               smp_credit_i,
    input  emu_pkg::tbl_wr_t   tbl_wr_i,
    output logic               sym_credit_o,
    output logic               smp_valid_o,
    output emu_pkg::sample_t   smp_o
);
    import emu_pkg::*;

    localparam int N      = `EMU_NUM_SLICES;
    localparam int HIST_W = `EMU_HIST_SYMS * `EMU_BITS_PER_SYMBOL;
    localparam int COEF_W = `EMU_COEF_WIDTH;

    logic [HIST_W-1:0] history;
    logic              frame_start;
    logic [N-1:0]      slice_done;
    sample_t           slice_smp;
    logic              done_a [N];
    slice_smp_t        smp_a [N];
    tbl_rd_req_t       rd_req_a [N];
    logic [N-1:0]      slice_ack;
    logic [COEF_W-1:0] slice_rd_data;
    tbl_rd_req_t       tbl_req;
    logic              tbl_busy;
    logic [COEF_W-1:0] tbl_rd_data;

    // gather per-slice results into the frame record
    always_comb begin
        for (int j = 0; j < N; j++) begin
            slice_done[j]    = done_a[j];
            slice_smp.slc[j] = smp_a[j];
        end
    end

    frame_sequencer u_seq (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .sym_valid_i  (sym_valid_i),
        .sym_word_i   (sym_word_i),
        .slice_done_i (slice_done),
        .slice_smp_i  (slice_smp),
        .smp_credit_i (smp_credit_i),
        .sym_credit_o (sym_credit_o),
        .history_o    (history),
        .start_o      (frame_start),
        .smp_valid_o  (smp_valid_o),
        .smp_o        (smp_o)
    );

    for (genvar j = 0; j < N; j++) begin : g_slice
        response_slice #(
            .SLICE_IDX (j)
        ) u_slice (
            .emu_clk   (emu_clk),
            .emu_rst   (emu_rst),
            .start_i   (frame_start),
            .history_i (history),
            .rd_ack_i  (slice_ack[j]),
            .rd_data_i (slice_rd_data),
            .rd_req_o  (rd_req_a[j]),
            .done_o    (done_a[j]),
            .smp_o     (smp_a[j])
        );
    end

    table_arbiter u_arb (
        .emu_clk    (emu_clk),
        .emu_rst    (emu_rst),
        .req_i      (rd_req_a),
        .tbl_busy_i (tbl_busy),
        .rd_data_i  (tbl_rd_data),
        .grant_o    (),
        .tbl_req_o  (tbl_req),
        .ack_o      (slice_ack),
        .rd_data_o  (slice_rd_data)
    );

    response_table u_tbl (
        .emu_clk    (emu_clk),
        .tbl_wr_i   (tbl_wr_i),
        .rd_req_i   (tbl_req),
        .tbl_busy_o (tbl_busy),
        .rd_data_o  (tbl_rd_data)
    );

endmodule

// File: verif/adc_emu_assert.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module adc_emu_assert #(
    parameter int CRED_W = $clog2(`EMU_OUT_CREDITS + 1),
    parameter int CNT_W  = $clog2(`EMU_IN_CREDITS + 1)
) (
    input logic              emu_clk,
    input logic              emu_rst,
    input logic              sym_valid_i,
    input logic              smp_valid_i,
    input logic [CRED_W-1:0] out_cred_i, // sequencer output credit counter
    input logic [CNT_W-1:0]  buf_cnt_i   // words held in the input buffer
);
    int fail_cnt = 0;

    // credits only come back for records already sent
    a_cred_bound : assert property (@(posedge emu_clk) disable iff (emu_rst)
        out_cred_i <= CRED_W'(`EMU_OUT_CREDITS))
    else begin
        $error("output credit counter above its starting value");
        fail_cnt++;
    end

    a_smp_has_credit : assert property (@(posedge emu_clk) disable iff (emu_rst)
        smp_valid_i |-> (out_cred_i != '0))
    else begin
        $error("sample record sent with no output credit");
        fail_cnt++;
    end

    a_no_overrun : assert property (@(posedge emu_clk) disable iff (emu_rst)
        sym_valid_i |-> (buf_cnt_i < CNT_W'(`EMU_IN_CREDITS)))
    else begin
        $error("symbol word sent into a full input buffer");
        fail_cnt++;
    end

endmodule

bind adc_emu_top adc_emu_assert u_assert (
    .emu_clk     (emu_clk),
    .emu_rst     (emu_rst),
    .sym_valid_i (sym_valid_i),
    .smp_valid_i (smp_valid_o),
    .out_cred_i  (u_seq.out_cred_q),
    .buf_cnt_i   (u_seq.buf_cnt_q)
);

// File: verif/adc_emu_tb.sv
`timescale 1ns/1ps
`include "emu_cfg.svh"

module adc_emu_tb;
    import emu_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int CHUNK_VALS = 1 << (`EMU_CHUNK_SYMS * `EMU_BITS_PER_SYMBOL);
    localparam int HOLD_AT    = 2;  // consumer withholds credits after this many samples
    localparam int HOLD_LEN   = 80; // cycles without credit returns

    logic      emu_clk;
    logic      emu_rst;
    logic      sym_valid_i;
    sym_word_t sym_word_i;
    logic      smp_credit_i;
    tbl_wr_t   tbl_wr_i;
    logic      sym_credit_o;
    logic      smp_valid_o;
    sample_t   smp_o;

    logic [`EMU_COEF_WIDTH-1:0] tbl_img [`EMU_TBL_DEPTH];
    sym_word_t   word_q [$];
    sample_t     want_q [$];
    int          n_frames     = 0;
    bit          cases_ready  = 1'b0;
    logic [31:0] lcg_state    = 32'h66c0_19a4;
    int          in_credits   = `EMU_IN_CREDITS; // producer side
    int          words_sent   = 0;
    int          credits_seen = 0;
    int          smp_rcvd     = 0;
    int          outstanding  = 0; // samples not yet credited back
    int          quiet_pulses = 0;
    bit          holding      = 1'b0;

    initial begin
        emu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) emu_clk = ~emu_clk;
    end

    adc_emu_top i_dut (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .sym_valid_i  (sym_valid_i),
        .sym_word_i   (sym_word_i),
        .smp_credit_i (smp_credit_i),
        .tbl_wr_i     (tbl_wr_i),
        .sym_credit_o (sym_credit_o),
        .smp_valid_o  (smp_valid_o),
        .smp_o        (smp_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t want);
        if (got !== want) begin
            abort_run($sformatf("FAIL time=%0t %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("FAIL time=%0t %s got %0d expected %0d", $time, name, got, want));
        end
    endtask

    // T lines fill the table image, F lines queue a word and its expected record
    task automatic read_cases();
        int      fd;
        int      rc;
        int      k;
        int      val;
        int      sgn;
        int      mag;
        string   tok;
        string   rest;
        sample_t want;
        fd = $fopen("verif/adc_emu_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the case file verif/adc_emu_cases.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(rest, fd);
            end else if (tok == "T") begin
                rc = $fscanf(fd, "%d", k);
                if (k < 0 || k >= `EMU_NUM_CHUNKS) begin
                    abort_run("table line in the case file has a chunk index out of range");
                end
                for (int v = 0; v < CHUNK_VALS; v++) begin
                    rc = $fscanf(fd, "%h", val);
                    tbl_img[k*CHUNK_VALS + v] = val[`EMU_COEF_WIDTH-1:0];
                end
            end else if (tok == "F") begin
                rc = $fscanf(fd, "%h", val);
                word_q.push_back(sym_word_t'(val[$bits(sym_word_t)-1:0]));
                for (int j = 0; j < `EMU_NUM_SLICES; j++) begin
                    rc = $fscanf(fd, "%d %d", sgn, mag);
                    want.slc[j].sign = sgn[0];
                    want.slc[j].mag  = mag[`EMU_MAG_WIDTH-1:0];
                end
                want_q.push_back(want);
            end else begin
                abort_run({"unknown line tag in the case file: ", tok});
            end
        end
        $fclose(fd);
    endtask

    task automatic count_quiet();
        quiet_pulses += (sym_credit_o !== 1'b0) + (smp_valid_o !== 1'b0);
    endtask

    // sample outputs at the falling edge, then drive the next inputs
    task automatic run_cycle();
        bit got_credit;
        @(negedge emu_clk);
        if (i_dut.u_assert.fail_cnt != 0) begin
            abort_run("a credit rule assertion fired inside the DUT");
        end
        got_credit = (sym_credit_o === 1'b1);
        if (got_credit) credits_seen++;
        if (smp_valid_o === 1'b1) begin
            if (smp_rcvd >= n_frames) abort_run("sample record arrived after the last frame");
            check_sample($sformatf("smp_o frame %0d", smp_rcvd), smp_o, want_q[smp_rcvd]);
            smp_rcvd++;
            outstanding++;
            if (outstanding > `EMU_OUT_CREDITS) begin
                abort_run("sample record arrived without an output credit");
            end
        end
        // producer spends a credit per word, a returned credit counts from next cycle
        if (in_credits > 0 && words_sent < n_frames) begin
            sym_valid_i = 1'b1;
            sym_word_i  = word_q[words_sent];
            words_sent++;
            in_credits--;
        end else begin
            sym_valid_i = 1'b0;
        end
        if (got_credit) in_credits++;
        lcg_state = lcg_next(lcg_state);
        if (!holding && outstanding > 0 && lcg_state[31:30] != 2'b00) begin
            smp_credit_i = 1'b1;
            outstanding--;
        end else begin
            smp_credit_i = 1'b0;
        end
    endtask

    initial begin
        int hold_left;
        bit hold_done;
        emu_rst      = 1'b1;
        sym_valid_i  = 1'b0;
        sym_word_i   = '0;
        smp_credit_i = 1'b0;
        tbl_wr_i     = '0;
        hold_left    = 0;
        hold_done    = 1'b0;
        read_cases();
        n_frames = word_q.size();
        cases_ready = 1'b1;
        repeat (5) @(negedge emu_clk);
        emu_rst = 1'b0;

        // table load, no word yet so both links must stay quiet
        for (int a = 0; a < `EMU_TBL_DEPTH; a++) begin
            @(negedge emu_clk);
            count_quiet();
            tbl_wr_i = '{en: 1'b1, addr: TBL_AW'(a), data: tbl_img[a]};
        end
        repeat (8) begin
            @(negedge emu_clk);
            count_quiet();
            tbl_wr_i = '0;
        end
        check_count("pulses on smp_valid_o and sym_credit_o before a word", quiet_pulses, 0);

        while (smp_rcvd < n_frames) begin
            run_cycle();
            if (holding) begin
                hold_left--;
                if (hold_left == 0) begin
                    check_count("samples received during the credit hold", outstanding,
                                `EMU_OUT_CREDITS);
                    holding = 1'b0;
                end
            end else if (!hold_done && smp_rcvd >= HOLD_AT) begin
                holding   = 1'b1;
                hold_done = 1'b1;
                hold_left = HOLD_LEN;
            end
        end
        repeat (4) run_cycle(); // a stray record would show up here

        check_count("sym_credit_o pulses", credits_seen, words_sent);
        check_count("words accepted", words_sent, n_frames);
        @(negedge emu_clk); // last driven inputs pass one rising edge of the assertions
        if (i_dut.u_assert.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("a credit rule assertion fired inside the DUT");
        end
    end

    // allowance covers reset, table load, the credit hold and each frame
    initial begin
        int limit;
        wait (cases_ready);
        limit = 5 + `EMU_TBL_DEPTH + 8 + HOLD_LEN + 100 * n_frames;
        #(limit * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles, %0d of %0d samples received",
                            limit, smp_rcvd, n_frames));
    end

endmodule

// File: verif/adc_emu_cases.txt
# T <chunk index> <entries for chunk values 0..15, hex, 12-bit two's complement>
# F <word hex, symbol 0 in low bits> <sign magnitude> for slices 0..3, magnitude decimal
T 0 000 001 002 003 004 005 006 007 008 009 00a 00b 00c 00d 00e 00f
T 1 000 010 020 030 040 050 060 070 080 090 0a0 0b0 0c0 0d0 0e0 0f0
T 2 000 fe0 fc0 fa0 f80 f60 f40 f20 f00 ee0 ec0 ea0 e80 e60 e40 e20
T 3 000 040 080 0c0 100 140 180 1c0 200 240 280 2c0 300 340 7ff 800
# first frames against an empty history
F 39 0 256 0 576 0 1023 1 96
F c6 0 128 0 432 0 36 0 633
F 9f 1 1023 1 1023 1 8 0 294
# windows now fully inside the stream
F e4 0 145 0 220 0 639 0 1023
F 1b 1 1023 0 329 0 50 1 60
F fe 0 569 0 1023 1 1023 1 1023
F eb 1 1023 0 449 0 408 0 1023
F 85 0 383 0 63 0 15 0 587

// File: verilog.f
+incdir+include
hw/emu_pkg.sv
hw/frame_sequencer.sv
hw/response_slice.sv
hw/table_arbiter.sv
hw/response_table.sv
hw/adc_emu_top.sv
verif/adc_emu_assert.sv
verif/adc_emu_tb.sv
